/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -Wno-fatal
TOP       ?= sm_tb
FILELIST  ?= verilog.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* common/pio_pkg.sv */
// ====================
// Shared types and enums of the state machine
// ====================
`default_nettype none
`include "pio_settings.svh"

package pio_pkg;

  typedef logic [`PIO_DATA_W-1:0]         word_t;
  typedef logic [`PIO_PC_W-1:0]           pc_t;
  typedef logic [$clog2(`PIO_DATA_W+1)-1:0] count_t;  // 0 to 32

  typedef enum logic [2:0] {
    OP_JMP = 3'd0, OP_WAIT = 3'd1, OP_IN = 3'd2, OP_OUT = 3'd3,
    OP_PUSH_PULL = 3'd4, OP_MOV = 3'd5, OP_IRQ = 3'd6, OP_SET = 3'd7
  } opcode_e;

  // Codes 6 and 7 are not supported and never jump
  typedef enum logic [2:0] {
    COND_ALWAYS = 3'd0, COND_X_ZERO = 3'd1, COND_X_DEC = 3'd2,
    COND_Y_ZERO = 3'd3, COND_Y_DEC = 3'd4, COND_X_NE_Y = 3'd5
  } jmp_cond_e;

  typedef enum logic [2:0] {
    SRC_PINS = 3'd0, SRC_X = 3'd1, SRC_Y = 3'd2, SRC_NULL = 3'd3,
    SRC_ISR = 3'd6, SRC_OSR = 3'd7
  } src_e;

  typedef enum logic [2:0] {
    DEST_PINS = 3'd0, DEST_X = 3'd1, DEST_Y = 3'd2, DEST_NULL = 3'd3,
    DEST_ISR = 3'd6, DEST_OSR = 3'd7
  } dest_e;

  typedef enum logic [1:0] {
    BITOP_NONE = 2'd0, BITOP_INVERT = 2'd1, BITOP_REVERSE = 2'd2, BITOP_RESERVED = 2'd3
  } bit_op_e;

  // Ones in the low n bits, all ones for n of 32
  function automatic word_t low_mask(count_t n);
    return (n >= count_t'(`PIO_DATA_W)) ? '1 : ((word_t'(1) << n) - word_t'(1));
  endfunction

endpackage

`default_nettype wire

/* common/pio_settings.svh */
// ====================
// Width settings for the state machine, included by the package and RTL
// ====================
`ifndef PIO_SETTINGS_SVH
`define PIO_SETTINGS_SVH

`define PIO_DATA_W   32  // X, Y, ISR, OSR, FIFO words and pins
`define PIO_PC_W     5   // Program counter and jump address
`define PIO_INSTR_W  16
`define PIO_SET_W    5   // SET data and small pin counts

`endif

/* common/sm_regs_if.sv */
// ====================
// Strobes and register contents between the execute unit and the registers
// ====================
`timescale 1ns/1ps
`default_nettype none

interface sm_regs_if;
  pio_pkg::word_t  new_val;                       // Load or shift-in value
  logic            set_x, set_y, dec_x, dec_y;
  logic            set_isr, set_osr, shift_in, shift_out;
  pio_pkg::count_t shift_amt;                     // Already 1 to 32
  pio_pkg::word_t  x, y;
  pio_pkg::word_t  isr, osr;
  pio_pkg::word_t  osr_data;                      // Right-aligned OUT bits
  pio_pkg::count_t isr_count, osr_count;

  modport exec (
    output new_val, set_x, set_y, dec_x, dec_y,
    output set_isr, set_osr, shift_in, shift_out, shift_amt,
    input  x, y, isr, osr, osr_data
  );

  modport scratch (
    input  new_val, set_x, set_y, dec_x, dec_y,
    output x, y
  );

  modport shifter (
    input  new_val, set_isr, set_osr, shift_in, shift_out, shift_amt,
    output isr, osr, osr_data, isr_count, osr_count
  );
endinterface

`default_nettype wire

/* verification/sm_assertions.sv */
// ====================
// Concurrent checks on FIFO strobes and pin masks, bound to the top level
// ====================
`timescale 1ns/1ps
`default_nettype none

module sm_assertions (
  input logic           clk,
  input logic           rst,
  input logic           en,
  input logic           empty,
  input logic           full,
  input logic           push,
  input logic           pull,
  input pio_pkg::word_t output_pins_mask
);

  a_push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
    else $error("push raised while the FIFO is full");

  a_pull_not_empty: assert property (@(posedge clk) disable iff (rst) pull |-> !empty)
    else $error("pull raised while the FIFO is empty");

  a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(push && pull))
    else $error("push and pull high together");

  a_idle_mask: assert property (@(posedge clk) !en |-> output_pins_mask == '0)
    else $error("pin mask set while en is low");

endmodule

`default_nettype wire

/* verification/sm_tb.sv */
// ====================
// Table-driven testbench for the state machine with a small reference model
// ====================
`timescale 1ns/1ps
`default_nettype none

module sm_tb;

  localparam int N_STEPS      = 28;
  localparam int EDGE_TIMEOUT = 20;  // Polls of 1 ns
  localparam int PEND = 7, WRAP = 2, SET_BASE = 4, SET_CNT = 3, OUT_BASE = 30, OUT_CNT = 4;

  typedef struct {
    logic [15:0]    instr;
    logic           en, empty, full, dir, rnd;
    pio_pkg::pc_t   pc;
    logic           push, pull;
    pio_pkg::word_t dout, pins, mask;
  } step_t;

  logic           clk = 1'b0;
  logic           rst, en, empty, full, in_shift_dir, out_shift_dir, push, pull;
  logic [15:0]    instr;
  pio_pkg::word_t din, input_pins, dout, output_pins, output_pins_mask;
  pio_pkg::pc_t   pc, pend, wrap_target;
  logic [4:0]     pins_out_base, pins_set_base, pins_in_base;
  logic [5:0]     pins_out_count;
  logic [2:0]     pins_set_count;
  logic [31:0]    lfsr;
  pio_pkg::word_t mx, my, misr, mosr;  // Reference model registers
  pio_pkg::pc_t   mpc;
  step_t          steps [N_STEPS];

  sm_machine DUT (.*);

  bind sm_machine sm_assertions u_assertions (.*);

  always #4 clk = ~clk;

  task automatic stop_on_error();
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_word(string what, pio_pkg::word_t got, pio_pkg::word_t want);
    if (got !== want) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
      stop_on_error();
    end
  endtask

  task automatic check_pc(string what, pio_pkg::pc_t got, pio_pkg::pc_t want);
    if (got !== want) begin
      $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, want);
      stop_on_error();
    end
  endtask

  task automatic check_bit(string what, logic got, logic want);
    if (got !== want) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, want);
      stop_on_error();
    end
  endtask

  // Returns 1 ns after the next rising edge, polling half a step off the edges
  task automatic wait_rise();
    logic prev;
    int   polls;
    #0.5;
    prev = clk;
    #1;
    polls = 1;
    while (!(prev == 1'b0 && clk == 1'b1)) begin
      if (polls >= EDGE_TIMEOUT) begin
        $display("Timeout: no rising clock edge within %0d ns", EDGE_TIMEOUT);
        stop_on_error();
      end
      prev = clk;
      #1;
      polls++;
    end
    #0.5;
  endtask

  function automatic pio_pkg::word_t rand_word();
    pio_pkg::word_t w;
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // One step per bit
      w[b] = lfsr[0];
    end
    return w;
  endfunction

  function automatic pio_pkg::word_t read_src(logic [2:0] code, pio_pkg::word_t pins);
    case (code)
      3'd0:    return pins;  // Input base is 0
      3'd1:    return mx;
      3'd2:    return my;
      3'd6:    return misr;
      3'd7:    return mosr;
      default: return '0;
    endcase
  endfunction

  function automatic pio_pkg::word_t flip(pio_pkg::word_t v);
    pio_pkg::word_t r;
    for (int b = 0; b < 32; b++) begin
      r[31-b] = v[b];
    end
    return r;
  endfunction

  task automatic model_step(input logic [15:0] ins, input logic e, em, fu, dr,
                            input pio_pkg::word_t d, pi, output step_t r);
    pio_pkg::word_t v, m;
    int   n, base, cnt;
    logic stl, jp, wr;
    r = '{default: '0};
    stl = 1'b0;
    jp = 1'b0;
    wr = 1'b0;
    v = '0;
    base = OUT_BASE;
    cnt = OUT_CNT;
    n = (ins[4:0] == 5'd0) ? 32 : int'(ins[4:0]);
    m = (n == 32) ? '1 : ((32'd1 << n) - 32'd1);
    if (e) begin
      case (ins[15:13])
        3'd0: begin
          case (ins[7:5])
            3'd0: jp = 1'b1;
            3'd1: jp = (mx == 0);
            3'd2: begin
              jp = (mx != 0);  // Test first, then count down
              mx = mx - 32'd1;
            end
            3'd3: jp = (my == 0);
            3'd4: begin
              jp = (my != 0);
              my = my - 32'd1;
            end
            3'd5: jp = (mx != my);
            default: jp = 1'b0;
          endcase
        end
        3'd2: begin
          v = read_src(ins[7:5], pi) & m;
          misr = dr ? ((misr >> n) | (v << (32 - n))) : ((misr << n) | v);
        end
        3'd3: begin
          v = dr ? (mosr & m) : (mosr >> (32 - n));
          mosr = dr ? (mosr >> n) : (mosr << n);
          wr = (ins[7:5] == 3'd0);
          if (ins[7:5] == 3'd1) mx = v;
          if (ins[7:5] == 3'd2) my = v;
        end
        3'd4: begin
          if (!ins[7]) begin
            stl = ins[5] && fu;
            if (!stl) begin
              r.push = !fu;
              r.dout = fu ? '0 : misr;
              misr = '0;
            end
          end else begin
            stl = ins[5] && em;
            if (!stl) begin
              r.pull = !em;
              mosr = em ? mx : d;  // Empty non-blocking pull copies X
            end
          end
        end
        3'd5: begin
          if (ins[2:0] inside {3'd0, 3'd1, 3'd2, 3'd3, 3'd6, 3'd7}) begin
            v = read_src(ins[2:0], pi);
            if (ins[4:3] == 2'd1) v = ~v;
            else if (ins[4:3] == 2'd2) v = flip(v);
            wr = (ins[7:5] == 3'd0);
            if (ins[7:5] == 3'd1) mx = v;
            if (ins[7:5] == 3'd2) my = v;
            if (ins[7:5] == 3'd6) misr = v;
            if (ins[7:5] == 3'd7) mosr = v;
          end
        end
        3'd7: begin
          v = pio_pkg::word_t'(ins[4:0]);
          base = SET_BASE;
          cnt = SET_CNT;
          wr = (ins[7:5] == 3'd0);
          if (ins[7:5] == 3'd1) mx = v;
          if (ins[7:5] == 3'd2) my = v;
        end
        default: ;
      endcase
      for (int i = 0; i < cnt; i++) begin
        if (wr) begin
          r.mask[(base + i) % 32] = 1'b1;
          r.pins[(base + i) % 32] = v[i];
        end
      end
      if (!stl) mpc = jp ? pio_pkg::pc_t'(ins[4:0]) : ((mpc == PEND) ? WRAP : mpc + 1'b1);
    end
    r.pc = mpc;
  endtask

  initial begin
    step_t want;
    int    k;
    // instr, en, empty, full, dir, rnd, pc, push, pull, dout, pins, mask
    steps = '{
      '{16'hE005, 1, 0, 0, 1, 0, 1, 0, 0, 0, 32'h0000_0050, 32'h0000_0070},
      '{16'hE005, 0, 0, 0, 1, 0, 1, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'hE023, 1, 0, 0, 1, 0, 2, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'hE046, 1, 0, 0, 1, 0, 3, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'hA001, 1, 0, 0, 1, 0, 4, 0, 0, 0, 32'hC000_0000, 32'hC000_0003},
      '{16'hA002, 1, 0, 0, 1, 0, 5, 0, 0, 0, 32'h8000_0001, 32'hC000_0003},
      '{16'h0043, 1, 0, 0, 1, 0, 3, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h0043, 1, 0, 0, 1, 0, 3, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h0043, 1, 0, 0, 1, 0, 3, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h0043, 1, 0, 0, 1, 0, 4, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h0007, 1, 0, 0, 1, 0, 7, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'hE021, 1, 0, 0, 1, 0, 2, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h80A0, 1, 1, 0, 1, 0, 2, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h80A0, 1, 1, 0, 1, 0, 2, 0, 0, 0, 32'h0000_0000, 32'h0000_0000},
      '{16'h80A0, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h6000, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h8080, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h6000, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0},
      '{16'h4010, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h4028, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h4044, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h8020, 1, 0, 1, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h8020, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h8080, 1, 1, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'hA007, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'hA00B, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'hA011, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0},
      '{16'h0043, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0}
    };
    lfsr = 32'd1441;
    {mx, my, misr, mosr} = '0;
    mpc = '0;
    rst = 1'b1;
    en = 1'b0;
    instr = '0;
    din = '0;
    input_pins = '0;
    empty = 1'b1;
    full = 1'b0;
    in_shift_dir = 1'b1;
    out_shift_dir = 1'b1;
    pend = pio_pkg::pc_t'(PEND);
    wrap_target = pio_pkg::pc_t'(WRAP);
    pins_set_base = 5'(SET_BASE);
    pins_set_count = 3'(SET_CNT);
    pins_out_base = 5'(OUT_BASE);  // Window crosses pin 31
    pins_out_count = 6'(OUT_CNT);
    pins_in_base = 5'd0;
    repeat (10) wait_rise();
    rst = 1'b0;
    for (k = 0; k < N_STEPS; k++) begin
      if (k > 0) begin
        wait_rise();
        check_pc($sformatf("step %0d pc", k - 1), pc, want.pc);
      end
      instr = steps[k].instr;
      en = steps[k].en;
      empty = steps[k].empty;
      full = steps[k].full;
      in_shift_dir = steps[k].dir;
      out_shift_dir = steps[k].dir;
      din = steps[k].rnd ? rand_word() : '0;
      input_pins = steps[k].rnd ? rand_word() : '0;
      model_step(instr, en, empty, full, steps[k].dir, din, input_pins, want);
      if (!steps[k].rnd) want = steps[k];
      #5;
      check_bit($sformatf("step %0d push", k), push, want.push);
      check_bit($sformatf("step %0d pull", k), pull, want.pull);
      check_word($sformatf("step %0d dout", k), dout, want.dout);
      check_word($sformatf("step %0d output_pins", k), output_pins, want.pins);
      check_word($sformatf("step %0d output_pins_mask", k), output_pins_mask, want.mask);
    end
    wait_rise();
    check_pc($sformatf("step %0d pc", N_STEPS - 1), pc, want.pc);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/pio_pkg.sv
common/sm_regs_if.sv
verilog/execute/exec_unit.sv
verilog/pc_counter.sv
verilog/scratch_regs.sv
verilog/shift_unit/shift_unit.sv
verilog/sm_machine.sv
verification/sm_assertions.sv
verification/sm_tb.sv

/* verilog/execute/exec_unit.sv */
// ====================
// Combinational decode and execute of the instruction on instr
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "pio_settings.svh"

module exec_unit (
  input  logic                    en,
  input  logic [`PIO_INSTR_W-1:0] instr,
  input  pio_pkg::word_t          din,
  input  logic                    empty,
  input  logic                    full,
  input  pio_pkg::word_t          input_pins,
  input  logic [4:0]              pins_out_base,
  input  logic [5:0]              pins_out_count,
  input  logic [4:0]              pins_set_base,
  input  logic [2:0]              pins_set_count,
  input  logic [4:0]              pins_in_base,
  input  logic                    in_shift_dir,
  sm_regs_if.exec                 regs,
  output logic                    jmp,
  output pio_pkg::pc_t            jmp_addr,
  output logic                    stall,
  output logic                    push,
  output logic                    pull,
  output pio_pkg::word_t          dout,
  output pio_pkg::word_t          output_pins,
  output pio_pkg::word_t          output_pins_mask
);

  pio_pkg::opcode_e       op;
  pio_pkg::jmp_cond_e     cond;
  pio_pkg::dest_e         dest;
  pio_pkg::src_e          src_sel;
  pio_pkg::bit_op_e       mov_op;
  pio_pkg::count_t        bit_cnt;
  logic [`PIO_SET_W-1:0]  data;
  logic                   blocking;
  logic [2*`PIO_DATA_W-1:0] pins_dup;
  pio_pkg::word_t         in_pins, src_val, mov_val, in_bits, in_aligned;
  logic                   src_ok, act;
  logic                   jmp_c, stall_c, push_c, pull_c;
  logic                   set_x_c, set_y_c, dec_x_c, dec_y_c;
  logic                   set_isr_c, set_osr_c, shift_in_c, shift_out_c;
  pio_pkg::word_t         new_val_c, pin_val;
  logic                   pin_wr;
  logic [4:0]             pin_base;
  pio_pkg::count_t        pin_cnt;

  function automatic pio_pkg::word_t apply_op(pio_pkg::word_t v, pio_pkg::bit_op_e o);
    case (o)
      pio_pkg::BITOP_INVERT:  return ~v;
      pio_pkg::BITOP_REVERSE: return {<<{v}};
      pio_pkg::BITOP_NONE, pio_pkg::BITOP_RESERVED: return v;
      default:                return v;
    endcase
  endfunction

  assign op       = pio_pkg::opcode_e'(instr[15:13]);
  assign cond     = pio_pkg::jmp_cond_e'(instr[7:5]);
  assign dest     = pio_pkg::dest_e'(instr[7:5]);
  assign mov_op   = pio_pkg::bit_op_e'(instr[4:3]);
  assign src_sel  = (op == pio_pkg::OP_MOV) ? pio_pkg::src_e'(instr[2:0])
                                            : pio_pkg::src_e'(instr[7:5]);
  assign data     = instr[`PIO_SET_W-1:0];
  assign blocking = instr[5];
  assign bit_cnt  = (data == '0) ? pio_pkg::count_t'(`PIO_DATA_W) : pio_pkg::count_t'(data);
  assign jmp_addr = pio_pkg::pc_t'(instr[4:0]);

  // Rotate right so that pin pins_in_base lands in bit 0
  assign pins_dup = {input_pins, input_pins} >> pins_in_base;
  assign in_pins  = pins_dup[`PIO_DATA_W-1:0];

  always_comb begin
    src_ok = 1'b1;
    case (src_sel)
      pio_pkg::SRC_PINS: src_val = in_pins;
      pio_pkg::SRC_X:    src_val = regs.x;
      pio_pkg::SRC_Y:    src_val = regs.y;
      pio_pkg::SRC_NULL: src_val = '0;
      pio_pkg::SRC_ISR:  src_val = regs.isr;
      pio_pkg::SRC_OSR:  src_val = regs.osr;
      default: begin
        src_val = '0;
        src_ok  = 1'b0;
      end
    endcase
  end

  assign mov_val = apply_op(src_val, mov_op);

  // Right shifts enter at the top of the ISR
  assign in_bits    = src_val & pio_pkg::low_mask(bit_cnt);
  assign in_aligned = in_shift_dir ? in_bits << (pio_pkg::count_t'(`PIO_DATA_W) - bit_cnt)
                                   : in_bits;

  always_comb begin
    jmp_c       = 1'b0;
    stall_c     = 1'b0;
    push_c      = 1'b0;
    pull_c      = 1'b0;
    set_x_c     = 1'b0;
    set_y_c     = 1'b0;
    dec_x_c     = 1'b0;
    dec_y_c     = 1'b0;
    set_isr_c   = 1'b0;
    set_osr_c   = 1'b0;
    shift_in_c  = 1'b0;
    shift_out_c = 1'b0;
    new_val_c   = '0;
    pin_wr      = 1'b0;
    pin_val     = '0;
    pin_base    = pins_out_base;
    pin_cnt     = pio_pkg::count_t'(pins_out_count);
    case (op)
      pio_pkg::OP_JMP: begin
        case (cond)
          pio_pkg::COND_ALWAYS: jmp_c = 1'b1;
          pio_pkg::COND_X_ZERO: jmp_c = (regs.x == '0);
          pio_pkg::COND_X_DEC: begin
            jmp_c   = (regs.x != '0);  // Tested before the decrement
            dec_x_c = 1'b1;
          end
          pio_pkg::COND_Y_ZERO: jmp_c = (regs.y == '0);
          pio_pkg::COND_Y_DEC: begin
            jmp_c   = (regs.y != '0);
            dec_y_c = 1'b1;
          end
          pio_pkg::COND_X_NE_Y: jmp_c = (regs.x != regs.y);
          default:              jmp_c = 1'b0;
        endcase
      end
      pio_pkg::OP_IN: begin
        shift_in_c = src_sel inside {pio_pkg::SRC_PINS, pio_pkg::SRC_X,
                                     pio_pkg::SRC_Y, pio_pkg::SRC_NULL};
        new_val_c  = in_aligned;
      end
      pio_pkg::OP_OUT: begin
        shift_out_c = dest inside {pio_pkg::DEST_PINS, pio_pkg::DEST_X,
                                   pio_pkg::DEST_Y, pio_pkg::DEST_NULL};
        pin_wr      = (dest == pio_pkg::DEST_PINS);
        set_x_c     = (dest == pio_pkg::DEST_X);
        set_y_c     = (dest == pio_pkg::DEST_Y);
        new_val_c   = regs.osr_data;
        pin_val     = regs.osr_data;
      end
      pio_pkg::OP_PUSH_PULL: begin
        if (!instr[7]) begin
          stall_c   = blocking && full;
          push_c    = !full;
          set_isr_c = 1'b1;  // ISR clears even when a full FIFO drops the word
        end else begin
          stall_c   = blocking && empty;
          pull_c    = !empty;
          set_osr_c = 1'b1;
          new_val_c = empty ? regs.x : din;  // Non-blocking on empty takes X
        end
      end
      pio_pkg::OP_MOV: begin
        pin_wr    = src_ok && (dest == pio_pkg::DEST_PINS);
        set_x_c   = src_ok && (dest == pio_pkg::DEST_X);
        set_y_c   = src_ok && (dest == pio_pkg::DEST_Y);
        set_isr_c = src_ok && (dest == pio_pkg::DEST_ISR);
        set_osr_c = src_ok && (dest == pio_pkg::DEST_OSR);
        new_val_c = mov_val;
        pin_val   = mov_val;
      end
      pio_pkg::OP_SET: begin
        pin_wr    = (dest == pio_pkg::DEST_PINS);
        set_x_c   = (dest == pio_pkg::DEST_X);
        set_y_c   = (dest == pio_pkg::DEST_Y);
        new_val_c = pio_pkg::word_t'(data);
        pin_val   = pio_pkg::word_t'(data);
        pin_base  = pins_set_base;
        pin_cnt   = pio_pkg::count_t'(pins_set_count);
      end
      default: ;  // WAIT and IRQ do nothing
    endcase
  end

  assign act   = en & ~stall_c;
  assign stall = en & stall_c;
  assign jmp   = act & jmp_c;
  assign push  = act & push_c;
  assign pull  = act & pull_c;
  assign dout  = push ? regs.isr : '0;

  assign regs.new_val   = new_val_c;
  assign regs.shift_amt = bit_cnt;
  assign regs.set_x     = act & set_x_c;
  assign regs.set_y     = act & set_y_c;
  assign regs.dec_x     = act & dec_x_c;
  assign regs.dec_y     = act & dec_y_c;
  assign regs.set_isr   = act & set_isr_c;
  assign regs.set_osr   = act & set_osr_c;
  assign regs.shift_in  = act & shift_in_c;
  assign regs.shift_out = act & shift_out_c;

  // Pin window wraps modulo 32 through the 5-bit index
  always_comb begin
    output_pins      = '0;
    output_pins_mask = '0;
    if (act && pin_wr) begin
      for (int i = 0; i < `PIO_DATA_W; i++) begin
        if (i < pin_cnt) begin
          output_pins_mask[pin_base + 5'(i)] = 1'b1;
          output_pins[pin_base + 5'(i)]      = pin_val[i];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pc_counter.sv */
// ====================
// Program counter with jump, stall hold and wrap from pend
// ====================
`timescale 1ns/1ps
`default_nettype none

module pc_counter (
  input  logic         clk,
  input  logic         rst,
  input  logic         en,
  input  logic         jmp,
  input  pio_pkg::pc_t jmp_addr,
  input  logic         stall,
  input  pio_pkg::pc_t pend,
  input  pio_pkg::pc_t wrap_target,
  output pio_pkg::pc_t pc
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (en && !stall) begin
      if (jmp) begin
        pc <= jmp_addr;
      end else if (pc == pend) begin
        pc <= wrap_target;  // End of program loops back
      end else begin
        pc <= pc + pio_pkg::pc_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/scratch_regs.sv */
// ====================
// X and Y scratch registers with load and wrapping decrement
// ====================
`timescale 1ns/1ps
`default_nettype none

module scratch_regs (
  input  logic      clk,
  input  logic      rst,
  sm_regs_if.scratch regs
);

  always_ff @(posedge clk) begin
    if (rst) begin
      regs.x <= '0;
      regs.y <= '0;
    end else begin
      if (regs.set_x) begin
        regs.x <= regs.new_val;
      end else if (regs.dec_x) begin
        regs.x <= regs.x - 1'b1;  // 0 wraps to all ones
      end
      if (regs.set_y) begin
        regs.y <= regs.new_val;
      end else if (regs.dec_y) begin
        regs.y <= regs.y - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/shift_unit/shift_unit.sv */
// ====================
// ISR and OSR with shift counters, shift-in and shift-out paths
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "pio_settings.svh"

module shift_unit (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_shift_dir,   // 1 shifts right
  input  logic       out_shift_dir,  // 1 shifts right
  sm_regs_if.shifter regs
);

  localparam pio_pkg::count_t FULL_CNT = pio_pkg::count_t'(`PIO_DATA_W);

  function automatic pio_pkg::count_t sat_add(pio_pkg::count_t a, pio_pkg::count_t b);
    logic [$bits(pio_pkg::count_t):0] sum;
    sum = a + b;
    return (sum > FULL_CNT) ? FULL_CNT : sum[$bits(pio_pkg::count_t)-1:0];
  endfunction

  // Low bits for a right shift, top bits brought down for a left shift
  assign regs.osr_data = out_shift_dir ? regs.osr & pio_pkg::low_mask(regs.shift_amt)
                                       : regs.osr >> (FULL_CNT - regs.shift_amt);

  always_ff @(posedge clk) begin
    if (rst) begin
      regs.isr       <= '0;
      regs.isr_count <= '0;
    end else if (regs.set_isr) begin
      regs.isr       <= regs.new_val;
      regs.isr_count <= '0;
    end else if (regs.shift_in) begin
      // new_val arrives already placed at the entry end
      regs.isr       <= (in_shift_dir ? regs.isr >> regs.shift_amt
                                      : regs.isr << regs.shift_amt) | regs.new_val;
      regs.isr_count <= sat_add(regs.isr_count, regs.shift_amt);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      regs.osr       <= '0;
      regs.osr_count <= FULL_CNT;  // Starts out as empty
    end else if (regs.set_osr) begin
      regs.osr       <= regs.new_val;
      regs.osr_count <= '0;
    end else if (regs.shift_out) begin
      regs.osr       <= out_shift_dir ? regs.osr >> regs.shift_amt
                                      : regs.osr << regs.shift_amt;
      regs.osr_count <= sat_add(regs.osr_count, regs.shift_amt);
    end
  end

endmodule

`default_nettype wire

/* verilog/sm_machine.sv */
// ====================
// State machine top level with plain ports, one instruction per enabled cycle
// ====================
`timescale 1ns/1ps
`default_nettype none
`include "pio_settings.svh"

module sm_machine (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    en,
  input  logic [`PIO_INSTR_W-1:0] instr,
  input  pio_pkg::word_t          din,
  input  logic                    empty,
  input  logic                    full,
  input  pio_pkg::word_t          input_pins,
  input  pio_pkg::pc_t            pend,
  input  pio_pkg::pc_t            wrap_target,
  input  logic [4:0]              pins_out_base,
  input  logic [5:0]              pins_out_count,
  input  logic [4:0]              pins_set_base,
  input  logic [2:0]              pins_set_count,
  input  logic [4:0]              pins_in_base,
  input  logic                    in_shift_dir,
  input  logic                    out_shift_dir,
  output pio_pkg::pc_t            pc,
  output logic                    push,
  output logic                    pull,
  output pio_pkg::word_t          dout,
  output pio_pkg::word_t          output_pins,
  output pio_pkg::word_t          output_pins_mask
);

  logic         jmp;
  pio_pkg::pc_t jmp_addr;
  logic         stall;

  sm_regs_if regs ();

  exec_unit u_exec (
    .en               (en),
    .instr            (instr),
    .din              (din),
    .empty            (empty),
    .full             (full),
    .input_pins       (input_pins),
    .pins_out_base    (pins_out_base),
    .pins_out_count   (pins_out_count),
    .pins_set_base    (pins_set_base),
    .pins_set_count   (pins_set_count),
    .pins_in_base     (pins_in_base),
    .in_shift_dir     (in_shift_dir),
    .regs             (regs),
    .jmp              (jmp),
    .jmp_addr         (jmp_addr),
    .stall            (stall),
    .push             (push),
    .pull             (pull),
    .dout             (dout),
    .output_pins      (output_pins),
    .output_pins_mask (output_pins_mask)
  );

  pc_counter u_pc (
    .clk         (clk),
    .rst         (rst),
    .en          (en),
    .jmp         (jmp),
    .jmp_addr    (jmp_addr),
    .stall       (stall),
    .pend        (pend),
    .wrap_target (wrap_target),
    .pc          (pc)
  );

  scratch_regs u_scratch (
    .clk  (clk),
    .rst  (rst),
    .regs (regs)
  );

  shift_unit u_shift (
    .clk           (clk),
    .rst           (rst),
    .in_shift_dir  (in_shift_dir),
    .out_shift_dir (out_shift_dir),
    .regs          (regs)
  );

endmodule

`default_nettype wire
